//--- source/dcache_pkg.sv
package dcache_pkg;

    typedef logic [31:0] word_t;

    // the LRU is one bit per set, so two ways only
    localparam int NUM_WAYS = 2;

    localparam int BYTE_OFF_W = 2;

    // two words per block
    localparam int BLK_OFF_W = 1;

    typedef enum logic [3:0] {
        IDLE,
        WB_WORD0,
        WB_WORD1,
        FILL_WORD0,
        FILL_WORD1,
        FLUSH_CHECK,
        FLUSH_WORD0,
        FLUSH_WORD1,
        FLUSHED
    } ctrl_state_t;

    typedef enum logic [2:0] {
        WAY_NONE,
        WAY_WRITE_WORD,
        WAY_FILL_WORD,
        WAY_CLEAN,
        WAY_INVALIDATE_ALL
    } way_op_t;

endpackage

//--- source/dcache_way.sv
module dcache_way #(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W
) (
    input  logic                            CLK,
    input  logic                            n_rst,
    input  logic [IDX_W-1:0]                lookup_index,
    input  logic [TAG_W-1:0]                lookup_tag,
    input  dcache_pkg::way_op_t             way_op,
    input  logic                            selected,
    input  logic [IDX_W-1:0]                op_index,
    input  logic [dcache_pkg::BLK_OFF_W-1:0] op_blkoff,
    input  dcache_pkg::word_t               op_data,
    output logic                            hit,
    output logic                            dirty,
    output logic [TAG_W-1:0]                tag,
    output dcache_pkg::word_t               data0,
    output dcache_pkg::word_t               data1
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]    tag_q  [NUM_SETS];
    word_t [1:0]         data_q [NUM_SETS];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (selected) begin
            case (way_op)
                WAY_WRITE_WORD: begin
                    dirty_q[op_index] <= 1'b1;
                end
                WAY_FILL_WORD: begin
                    // block becomes valid with its second word
                    valid_q[op_index] <= (op_blkoff == BLK_OFF_W'(1));
                    dirty_q[op_index] <= 1'b0;
                end
                WAY_CLEAN: begin
                    dirty_q[op_index] <= 1'b0;
                end
                WAY_INVALIDATE_ALL: begin
                    valid_q <= '0;
                    dirty_q <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (selected && (way_op == WAY_WRITE_WORD || way_op == WAY_FILL_WORD)) begin
            data_q[op_index][op_blkoff] <= op_data;
        end
        // refill tag is the one the CPU is still holding
        if (selected && way_op == WAY_FILL_WORD) begin
            tag_q[op_index] <= lookup_tag;
        end
    end

    assign hit   = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign dirty = dirty_q[lookup_index];
    assign tag   = tag_q[lookup_index];
    assign data0 = data_q[lookup_index][0];
    assign data1 = data_q[lookup_index][1];

endmodule

//--- source/way_select.sv
module way_select #(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W
) (
    input  logic                                         CLK,
    input  logic                                         n_rst,
    input  logic [dcache_pkg::NUM_WAYS-1:0]              way_hit,
    input  logic [dcache_pkg::NUM_WAYS-1:0]              way_dirty,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0]   way_tag,
    input  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] way_data0,
    input  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] way_data1,
    input  logic [IDX_W-1:0]                             index,
    input  logic [dcache_pkg::BLK_OFF_W-1:0]             blkoff,
    input  logic                                         access_hit,
    input  logic                                         lru_fill,
    input  logic                                         fill_way,
    output logic                                         any_hit,
    output logic                                         hit_way,
    output dcache_pkg::word_t                            rdata,
    output logic                                         victim_way,
    output logic                                         victim_dirty,
    output logic [TAG_W-1:0]                             victim_tag
);
    import dcache_pkg::*;

    // per set, the way to evict next
    logic [NUM_SETS-1:0] lru_q;

    always_comb begin
        hit_way = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = 1'(w);
            end
        end
    end

    assign any_hit = |way_hit;
    assign rdata   = (blkoff == BLK_OFF_W'(1)) ? way_data1[hit_way] : way_data0[hit_way];

    assign victim_way   = lru_q[index];
    assign victim_dirty = way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            lru_q <= '0;
        end else if (lru_fill) begin
            lru_q[index] <= ~fill_way;
        end else if (access_hit) begin
            lru_q[index] <= ~hit_way;
        end
    end

endmodule

//--- source/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int NUM_SETS = 8,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W
) (
    input  logic                                         CLK,
    input  logic                                         n_rst,
    input  logic                                         dmem_ren,
    input  logic                                         dmem_wen,
    input  dcache_pkg::word_t                            dmem_addr,
    input  dcache_pkg::word_t                            dmem_store,
    input  logic                                         halt,
    input  logic                                         any_hit,
    input  logic                                         hit_way,
    input  logic                                         victim_way,
    input  logic                                         victim_dirty,
    input  logic [TAG_W-1:0]                             victim_tag,
    input  logic [dcache_pkg::NUM_WAYS-1:0]              set_dirty,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0]   set_tag,
    input  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] set_data0,
    input  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] set_data1,
    input  logic                                         mem_wait,
    input  dcache_pkg::word_t                            mem_load,
    output logic                                         dhit,
    output logic                                         flushed,
    output logic                                         mem_ren,
    output logic                                         mem_wen,
    output dcache_pkg::word_t                            mem_addr,
    output dcache_pkg::word_t                            mem_store,
    output dcache_pkg::way_op_t                          way_op,
    output logic [dcache_pkg::NUM_WAYS-1:0]              way_sel,
    output logic [IDX_W-1:0]                             op_index,
    output logic [dcache_pkg::BLK_OFF_W-1:0]             op_blkoff,
    output dcache_pkg::word_t                            op_data,
    output logic                                         access_hit,
    output logic                                         lru_fill,
    output logic                                         fill_way,
    output logic [IDX_W-1:0]                             lookup_index
);
    import dcache_pkg::*;

    localparam int OFF_W = BLK_OFF_W + BYTE_OFF_W;
    localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(NUM_SETS - 1);

    ctrl_state_t          state;
    ctrl_state_t          next_state;
    logic [IDX_W-1:0]     flush_index;
    logic [IDX_W-1:0]     next_flush_index;
    logic                 tgt_way;
    logic                 next_tgt_way;
    logic                 fl_way;
    logic                 next_mem_ren;
    logic                 next_mem_wen;
    word_t                next_mem_addr;
    word_t                next_mem_store;
    logic [TAG_W-1:0]     cpu_tag;
    logic [IDX_W-1:0]     cpu_index;
    logic [BLK_OFF_W-1:0] cpu_blkoff;
    word_t                cpu_base;
    logic                 cpu_req;
    logic                 flush_mode;

    assign cpu_tag    = dmem_addr[31 -: TAG_W];
    assign cpu_index  = dmem_addr[OFF_W +: IDX_W];
    assign cpu_blkoff = dmem_addr[BYTE_OFF_W +: BLK_OFF_W];
    assign cpu_base   = {cpu_tag, cpu_index, {OFF_W{1'b0}}};
    assign cpu_req    = dmem_ren || dmem_wen;

    // during flush the ways look at the flush index
    assign flush_mode   = state inside {FLUSH_CHECK, FLUSH_WORD0, FLUSH_WORD1, FLUSHED};
    assign lookup_index = flush_mode ? flush_index : cpu_index;
    assign op_index     = lookup_index;

    assign dhit       = (state == IDLE) && cpu_req && any_hit;
    assign access_hit = dhit;
    assign flushed    = (state == FLUSHED);
    assign fill_way   = tgt_way;

    // lowest dirty way of the set being flushed
    always_comb begin
        fl_way = 1'b0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (set_dirty[w]) begin
                fl_way = 1'(w);
            end
        end
    end

    always_comb begin
        next_state       = state;
        next_flush_index = flush_index;
        next_tgt_way     = tgt_way;
        next_mem_ren     = mem_ren;
        next_mem_wen     = mem_wen;
        next_mem_addr    = mem_addr;
        next_mem_store   = mem_store;
        way_op           = WAY_NONE;
        way_sel          = '0;
        way_sel[tgt_way] = 1'b1;
        op_blkoff        = cpu_blkoff;
        op_data          = mem_load;
        lru_fill         = 1'b0;

        case (state)
            IDLE: begin
                if (dhit && dmem_wen) begin
                    way_op           = WAY_WRITE_WORD;
                    way_sel          = '0;
                    way_sel[hit_way] = 1'b1;
                    op_data          = dmem_store;
                end
                if (halt) begin
                    next_state       = FLUSH_CHECK;
                    next_flush_index = '0;
                end else if (cpu_req && !any_hit) begin
                    next_tgt_way = victim_way;
                    if (victim_dirty) begin
                        next_state     = WB_WORD0;
                        next_mem_wen   = 1'b1;
                        next_mem_addr  = {victim_tag, cpu_index, {OFF_W{1'b0}}};
                        next_mem_store = set_data0[victim_way];
                    end else begin
                        next_state    = FILL_WORD0;
                        next_mem_ren  = 1'b1;
                        next_mem_addr = cpu_base;
                    end
                end
            end
            WB_WORD0, FLUSH_WORD0: begin
                if (!mem_wait) begin
                    next_state     = (state == WB_WORD0) ? WB_WORD1 : FLUSH_WORD1;
                    next_mem_addr  = mem_addr + 32'd4;
                    next_mem_store = set_data1[tgt_way];
                end
            end
            WB_WORD1: begin
                if (!mem_wait) begin
                    way_op        = WAY_CLEAN;
                    next_state    = FILL_WORD0;
                    next_mem_wen  = 1'b0;
                    next_mem_ren  = 1'b1;
                    next_mem_addr = cpu_base;
                end
            end
            FILL_WORD0: begin
                if (!mem_wait) begin
                    way_op        = WAY_FILL_WORD;
                    op_blkoff     = '0;
                    next_state    = FILL_WORD1;
                    next_mem_addr = mem_addr + 32'd4;
                end
            end
            FILL_WORD1: begin
                if (!mem_wait) begin
                    way_op       = WAY_FILL_WORD;
                    op_blkoff    = BLK_OFF_W'(1);
                    lru_fill     = 1'b1;
                    next_state   = IDLE;
                    next_mem_ren = 1'b0;
                end
            end
            FLUSH_CHECK: begin
                if (|set_dirty) begin
                    next_tgt_way   = fl_way;
                    next_state     = FLUSH_WORD0;
                    next_mem_wen   = 1'b1;
                    next_mem_addr  = {set_tag[fl_way], flush_index, {OFF_W{1'b0}}};
                    next_mem_store = set_data0[fl_way];
                end else if (flush_index == LAST_SET) begin
                    way_op     = WAY_INVALIDATE_ALL;
                    way_sel    = '1;
                    next_state = FLUSHED;
                end else begin
                    next_flush_index = flush_index + 1'b1;
                end
            end
            FLUSH_WORD1: begin
                // back to the same set, the other way may still be dirty
                if (!mem_wait) begin
                    way_op       = WAY_CLEAN;
                    next_state   = FLUSH_CHECK;
                    next_mem_wen = 1'b0;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state       <= IDLE;
            flush_index <= '0;
            tgt_way     <= 1'b0;
            mem_ren     <= 1'b0;
            mem_wen     <= 1'b0;
        end else begin
            state       <= next_state;
            flush_index <= next_flush_index;
            tgt_way     <= next_tgt_way;
            mem_ren     <= next_mem_ren;
            mem_wen     <= next_mem_wen;
        end
    end

    always_ff @(posedge CLK) begin
        mem_addr  <= next_mem_addr;
        mem_store <= next_mem_store;
    end

endmodule

//--- source/dcache_top.sv
module dcache_top #(
    parameter int NUM_SETS = 8
) (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  logic              halt,
    output logic              dhit,
    output dcache_pkg::word_t dmem_load,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  logic              mem_wait,
    input  dcache_pkg::word_t mem_load
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - BLK_OFF_W - BYTE_OFF_W;

    logic [TAG_W-1:0]               cpu_tag;
    logic [BLK_OFF_W-1:0]           cpu_blkoff;
    way_op_t                        way_op;
    logic [NUM_WAYS-1:0]            way_sel;
    logic [IDX_W-1:0]               op_index;
    logic [IDX_W-1:0]               lookup_index;
    logic [BLK_OFF_W-1:0]           op_blkoff;
    word_t                          op_data;
    logic [NUM_WAYS-1:0]            way_hit;
    logic [NUM_WAYS-1:0]            way_dirty;
    logic [NUM_WAYS-1:0][TAG_W-1:0] way_tag;
    word_t [NUM_WAYS-1:0]           way_data0;
    word_t [NUM_WAYS-1:0]           way_data1;
    logic                           any_hit;
    logic                           hit_way;
    logic                           victim_way;
    logic                           victim_dirty;
    logic [TAG_W-1:0]               victim_tag;
    logic                           access_hit;
    logic                           lru_fill;
    logic                           fill_way;

    // index is split inside the controller, which owns the flush mux
    assign cpu_tag    = dmem_addr[31 -: TAG_W];
    assign cpu_blkoff = dmem_addr[BYTE_OFF_W +: BLK_OFF_W];

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
        .CLK(CLK),
        .n_rst(n_rst),
        .dmem_ren(dmem_ren),
        .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr),
        .dmem_store(dmem_store),
        .halt(halt),
        .any_hit(any_hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .set_dirty(way_dirty),
        .set_tag(way_tag),
        .set_data0(way_data0),
        .set_data1(way_data1),
        .mem_wait(mem_wait),
        .mem_load(mem_load),
        .dhit(dhit),
        .flushed(flushed),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_store(mem_store),
        .way_op(way_op),
        .way_sel(way_sel),
        .op_index(op_index),
        .op_blkoff(op_blkoff),
        .op_data(op_data),
        .access_hit(access_hit),
        .lru_fill(lru_fill),
        .fill_way(fill_way),
        .lookup_index(lookup_index)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way #(.NUM_SETS(NUM_SETS)) u_way (
            .CLK(CLK),
            .n_rst(n_rst),
            .lookup_index(lookup_index),
            .lookup_tag(cpu_tag),
            .way_op(way_op),
            .selected(way_sel[w]),
            .op_index(op_index),
            .op_blkoff(op_blkoff),
            .op_data(op_data),
            .hit(way_hit[w]),
            .dirty(way_dirty[w]),
            .tag(way_tag[w]),
            .data0(way_data0[w]),
            .data1(way_data1[w])
        );
    end

    way_select #(.NUM_SETS(NUM_SETS)) u_sel (
        .CLK(CLK),
        .n_rst(n_rst),
        .way_hit(way_hit),
        .way_dirty(way_dirty),
        .way_tag(way_tag),
        .way_data0(way_data0),
        .way_data1(way_data1),
        .index(lookup_index),
        .blkoff(cpu_blkoff),
        .access_hit(access_hit),
        .lru_fill(lru_fill),
        .fill_way(fill_way),
        .any_hit(any_hit),
        .hit_way(hit_way),
        .rdata(dmem_load),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

endmodule

//--- dv/dcache_sva.sv
module dcache_sva (
    input logic              CLK,
    input logic              n_rst,
    input logic              dmem_ren,
    input logic              dmem_wen,
    input logic              dhit,
    input logic              flushed,
    input logic              mem_ren,
    input logic              mem_wen,
    input dcache_pkg::word_t mem_addr,
    input dcache_pkg::word_t mem_store,
    input logic              mem_wait
);

    // number of failed assertions
    int unsigned fails = 0;

    a_ren_wen_excl: assert property (@(posedge CLK) disable iff (!n_rst)
        !(mem_ren && mem_wen))
    else begin
        fails++;
        $error("mem_ren and mem_wen high together");
    end

    // request held while the memory stalls
    a_req_stable: assert property (@(posedge CLK) disable iff (!n_rst)
        (mem_ren || mem_wen) && mem_wait |=>
            $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_store))
    else begin
        fails++;
        $error("memory request changed while mem_wait was high");
    end

    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!n_rst)
        flushed |=> flushed)
    else begin
        fails++;
        $error("flushed dropped before reset");
    end

    // a hit never overlaps an outstanding memory request
    a_dhit_req: assert property (@(posedge CLK) disable iff (!n_rst)
        dhit |-> (dmem_ren || dmem_wen) && !mem_ren && !mem_wen)
    else begin
        fails++;
        $error("dhit high without a CPU request or during a memory request");
    end

endmodule

//--- dv/dcache_tb.sv
module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_SETS = 8;
    localparam int N_RANDOM = 300;
    localparam int MAX_WAIT = 3;
    // dirty miss is four transactions, then the hit cycle and an idle gap
    localparam int REQ_CYCLES   = 4 * (MAX_WAIT + 2) + 3;
    localparam int FLUSH_CYCLES = NUM_SETS * (1 + NUM_WAYS * (2 * (MAX_WAIT + 2) + 1));
    localparam int CYCLE_LIMIT  = 17 + (N_RANDOM + 6) * REQ_CYCLES + FLUSH_CYCLES + 50;

    logic  CLK;
    logic  n_rst;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
    logic  dhit;
    word_t dmem_load;
    logic  flushed;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_store;
    logic  mem_wait;
    word_t mem_load;

    // CPU view of memory, and the responder's backing store
    word_t image [word_t];
    word_t mem   [word_t];
    int    req_cycles;
    int    cycles;
    int    wait_left;
    logic  wb_second;
    word_t wb_base;

    dcache_top #(.NUM_SETS(NUM_SETS)) u_dut (
        .CLK(CLK),
        .n_rst(n_rst),
        .dmem_ren(dmem_ren),
        .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr),
        .dmem_store(dmem_store),
        .halt(halt),
        .dhit(dhit),
        .dmem_load(dmem_load),
        .flushed(flushed),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_store(mem_store),
        .mem_wait(mem_wait),
        .mem_load(mem_load)
    );

    bind dcache_top dcache_sva u_sva (
        .CLK(CLK),
        .n_rst(n_rst),
        .dmem_ren(dmem_ren),
        .dmem_wen(dmem_wen),
        .dhit(dhit),
        .flushed(flushed),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_store(mem_store),
        .mem_wait(mem_wait)
    );

    function automatic word_t init_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic word_t model_value(input word_t a);
        return image.exists(a) ? image[a] : init_word(a);
    endfunction

    function automatic word_t mem_value(input word_t a);
        return mem.exists(a) ? mem[a] : init_word(a);
    endfunction

    // few sets, four tags each, so evictions happen often
    function automatic word_t pool_addr(input int tag_sel, input int set, input int blk);
        return 32'h0001_0000 + word_t'(tag_sel) * 32'h400 + word_t'(set) * 32'd8
            + word_t'(blk) * 32'd4;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic mismatch(input string msg);
        stop_with_error($sformatf("Fail at time %0t: %s", $time, msg));
    endtask

    task automatic check_write();
        if (!wb_second) begin
            assert (mem_addr[2:0] == 3'b000)
            else mismatch($sformatf("write-back to %h not block aligned", mem_addr));
            wb_base = mem_addr;
        end else begin
            assert (mem_addr == wb_base + 32'd4)
            else mismatch($sformatf("second write-back word at %h, base %h", mem_addr, wb_base));
        end
        wb_second = !wb_second;
        assert (mem_store == model_value(mem_addr))
        else mismatch($sformatf("write-back %h got %h expected %h",
            mem_addr, mem_store, model_value(mem_addr)));
        mem[mem_addr] = mem_store;
    endtask

    // holds the request until dhit, reports memory request cycles spent on it
    task automatic access(input logic wr, input word_t addr, input word_t data,
                          output int traffic);
        int start;
        dmem_ren   <= !wr;
        dmem_wen   <= wr;
        dmem_addr  <= addr;
        dmem_store <= data;
        @(negedge CLK);
        start = req_cycles;
        while (!dhit) begin
            @(negedge CLK);
        end
        traffic = req_cycles - start;
        if (wr) begin
            image[addr] = data;
        end else begin
            assert (dmem_load == model_value(addr))
            else mismatch($sformatf("read %h got %h expected %h",
                addr, dmem_load, model_value(addr)));
        end
        @(posedge CLK);
    endtask

    task automatic idle_cycle();
        dmem_ren <= 1'b0;
        dmem_wen <= 1'b0;
        @(posedge CLK);
    endtask

    // set 5: A, B, A, then C must evict B
    task automatic check_lru();
        word_t a;
        word_t b;
        word_t c;
        int    traffic;
        a = pool_addr(0, 5, 0);
        b = pool_addr(1, 5, 0);
        c = pool_addr(2, 5, 1);
        access(1'b0, a, '0, traffic);
        assert (traffic > 0) else stop_with_error("miss on an empty set made no memory request");
        access(1'b1, a + 32'd4, $urandom, traffic);
        assert (traffic == 0) else stop_with_error("access to a just filled block went to memory");
        access(1'b0, b, '0, traffic);
        access(1'b0, a, '0, traffic);
        assert (traffic == 0) else stop_with_error("hit on block A went to memory");
        access(1'b1, c, $urandom, traffic);
        assert (traffic > 0) else stop_with_error("miss on block C made no memory request");
        access(1'b0, a, '0, traffic);
        assert (traffic == 0) else stop_with_error("block A was evicted instead of block B");
    endtask

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge CLK);
            cycles++;
            assert (cycles <= CYCLE_LIMIT) else stop_with_error("timeout, the run did not finish");
            assert (u_dut.u_sva.fails == 0) else stop_with_error("a bound assertion failed");
        end
    end

    // memory responder, wait stays high until a request has been seen
    initial begin
        mem_wait   = 1'b1;
        mem_load   = '0;
        wait_left  = 0;
        wb_second  = 1'b0;
        req_cycles = 0;
        forever begin
            @(posedge CLK);
            if (mem_ren || mem_wen) begin
                req_cycles++;
                assert (!(halt && mem_ren)) else stop_with_error("memory read during the flush");
                if (!mem_wait) begin
                    if (mem_wen) begin
                        check_write();
                    end
                    mem_wait <= 1'b1;
                    wait_left = int'($urandom_range(MAX_WAIT, 0));
                end else if (wait_left == 0) begin
                    mem_wait <= 1'b0;
                    mem_load <= mem_value(mem_addr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        int    traffic;
        word_t addr;
        void'($urandom(32'h524ad08d));
        n_rst      = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        repeat (16) @(posedge CLK);
        n_rst <= 1'b1;
        @(posedge CLK);

        check_lru();

        for (int i = 0; i < N_RANDOM; i++) begin
            addr = pool_addr(int'($urandom_range(3, 0)), int'($urandom_range(2, 0)),
                int'($urandom_range(1, 0)));
            access($urandom_range(1, 0) == 1, addr, $urandom, traffic);
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end
        end

        dmem_ren <= 1'b0;
        dmem_wen <= 1'b0;
        halt     <= 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        foreach (image[a]) begin
            assert (mem_value(a) == image[a])
            else mismatch($sformatf("after flush memory %h holds %h expected %h",
                a, mem_value(a), image[a]));
        end

        if (u_dut.u_sva.fails == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_with_error("bound assertions reported failures");
        end
    end

endmodule

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module dcache_tb -f tb.f -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb.f
source/dcache_pkg.sv
source/dcache_way.sv
source/way_select.sv
source/dcache_ctrl.sv
source/dcache_top.sv
dv/dcache_sva.sv
dv/dcache_tb.sv
